// ==== verilog.f ====
rtl/saturn_bus_pkg.sv
rtl/saturn_bus_master.sv
rtl/saturn_io_regs.sv
rtl/saturn_nibble_ram.sv
rtl/saturn_bus_top.sv
dv/tb_saturn_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_saturn_bus -f verilog.f -o sim_tb

output="$(./obj_dir/sim_tb 2>&1)" || true
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// ==== dv/tb_saturn_bus.sv ====
// self-checking testbench for the nibble bus subsystem that runs as top over the files in verilog.f
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_bus
    import saturn_bus_pkg::*;
();

    localparam int BUS_DIV = 4;
    localparam int IO_WIN = 64;
    localparam int RAM_WIN = 256;
    localparam int NUM_RAND = 12;
    localparam logic [19:0] IO_BASE = 20'h00100;
    localparam logic [19:0] RAM_BASE = 20'h00200;
    // longest request is 11 strobes plus one idle slot
    localparam int TIMEOUT_CYCLES = (3 * NUM_RAND + 30) * 12 * BUS_DIV;

    logic        i_clk;
    logic        i_reset;
    logic        i_req_valid;
    host_req_t   i_req;
    logic        o_busy;
    logic        o_rd_done;
    logic [15:0] o_rd_data;
    logic [5:0]  o_menu_height;
    logic        o_rom_mode;

    // reference model of both devices
    logic [3:0]  io_model [IO_WIN];
    logic [3:0]  ram_model [RAM_WIN];
    logic        io_cfg;
    logic        ram_cfg;
    logic [19:0] io_base_m;
    logic [19:0] ram_base_m;
    logic [5:0]  exp_menu;
    logic        exp_rom;
    logic        read_pending;
    int          rd_done_count;
    int          cycle_count = 0;
    logic [19:0] saved_addr [NUM_RAND];
    logic [2:0]  saved_cnt [NUM_RAND];
    logic [3:0]  nib_lo;
    logic [3:0]  nib_hi;

    saturn_bus_top u_saturn_bus_top (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_busy       (o_busy),
        .o_rd_done    (o_rd_done),
        .o_rd_data    (o_rd_data),
        .o_menu_height(o_menu_height),
        .o_rom_mode   (o_rom_mode)
    );

    always #10 i_clk = ~i_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp)
            else abort_run($sformatf("Fail: time %0t signal %s expected %0h actual %0h",
                                     $time, name, exp, act));
    endtask

    // done pulse only belongs to a read in flight
    assert property (@(posedge i_clk) disable iff (i_reset) o_rd_done |-> read_pending)
        else abort_run($sformatf("Fail: time %0t signal o_rd_done expected 0 actual 1", $time));

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
            abort_run($sformatf("Timed out after %0d cycles with tests unfinished",
                                TIMEOUT_CYCLES));
    end

    always @(negedge i_clk) begin
        if (o_rd_done)
            rd_done_count++;
    end

    // claimed nibble at a bus address or zero outside both windows
    function automatic logic [3:0] model_read(input logic [19:0] addr);
        logic [19:0] io_ofs;
        logic [19:0] ram_ofs;
        logic [3:0]  nib;
        io_ofs = addr - io_base_m;
        ram_ofs = addr - ram_base_m;
        nib = 4'h0;
        if (io_cfg && io_ofs < 20'(IO_WIN))
            nib = io_model[io_ofs[5:0]];
        if (ram_cfg && ram_ofs < 20'(RAM_WIN))
            nib = nib | ram_model[ram_ofs[7:0]];
        return nib;
    endfunction

    task automatic model_write(input logic [19:0] addr, input logic [3:0] nib);
        logic [19:0] io_ofs;
        logic [19:0] ram_ofs;
        io_ofs = addr - io_base_m;
        ram_ofs = addr - ram_base_m;
        if (io_cfg && io_ofs < 20'(IO_WIN)) begin
            io_model[io_ofs[5:0]] = nib;
            if (io_ofs == 20'h28)
                exp_menu[3:0] = nib;
            if (io_ofs == 20'h29) begin
                exp_menu[5:4] = nib[1:0];
                exp_rom = nib[3];
            end
        end
        if (ram_cfg && ram_ofs < 20'(RAM_WIN))
            ram_model[ram_ofs[7:0]] = nib;
    endtask

    // first unconfigured device in daisy order takes the base
    task automatic model_configure(input logic [19:0] addr);
        if (!io_cfg) begin
            io_cfg = 1'b1;
            io_base_m = addr;
        end else if (!ram_cfg) begin
            ram_cfg = 1'b1;
            ram_base_m = addr;
        end
    endtask

    task automatic run_req(input host_op_e op, input logic [19:0] addr, input logic [2:0] count,
                           input logic [15:0] wdata);
        int          n_nib;
        int          strobes;
        int          busy_cycles;
        int          i;
        logic [15:0] exp_data;
        n_nib = int'(count);
        case (op)
            OP_CONFIGURE: strobes = 6;
            OP_READ:      strobes = 6 + n_nib;
            OP_WRITE:     strobes = 7 + n_nib;
            default:      strobes = 1;
        endcase
        exp_data = '0;
        busy_cycles = 0;
        while (o_busy)
            @(negedge i_clk);
        read_pending = (op == OP_READ);
        rd_done_count = 0;
        i_req = '{op: op, addr: addr, count: count, wdata: wdata};
        i_req_valid = 1'b1;
        @(negedge i_clk);
        i_req_valid = 1'b0;
        while (o_busy) begin
            busy_cycles++;
            // a reset request while busy has to be dropped
            i_req.op = OP_RESET;
            i_req_valid = (busy_cycles == 2);
            @(negedge i_clk);
        end
        i_req_valid = 1'b0;
        case (op)
            OP_CONFIGURE: model_configure(addr);
            OP_RESET: begin
                io_cfg = 1'b0;
                ram_cfg = 1'b0;
            end
            OP_WRITE: begin
                for (i = 0; i < n_nib; i++)
                    model_write(addr + 20'(i), wdata[i*4 +: 4]);
            end
            default: begin
                for (i = 0; i < n_nib; i++)
                    exp_data[i*4 +: 4] = model_read(addr + 20'(i));
            end
        endcase
        check_value("o_busy cycles", 32'(strobes * BUS_DIV), 32'(busy_cycles));
        check_value("o_rd_done pulses", (op == OP_READ) ? 32'd1 : 32'd0, 32'(rd_done_count));
        if (op == OP_READ)
            check_value("o_rd_data", 32'(exp_data), 32'(o_rd_data));
        check_value("o_menu_height", 32'(exp_menu), 32'(o_menu_height));
        check_value("o_rom_mode", 32'(exp_rom), 32'(o_rom_mode));
        read_pending = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hb30bdfa3));
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_req_valid = 1'b0;
        i_req = '0;
        io_cfg = 1'b0;
        ram_cfg = 1'b0;
        io_base_m = '0;
        ram_base_m = '0;
        exp_menu = '0;
        exp_rom = 1'b0;
        read_pending = 1'b0;
        rd_done_count = 0;
        repeat (5) @(negedge i_clk);
        i_reset = 1'b0;
        repeat (2) @(negedge i_clk);
        check_value("o_busy", 32'd0, 32'(o_busy));
        check_value("o_rd_done", 32'd0, 32'(o_rd_done));
        check_value("o_menu_height", 32'd0, 32'(o_menu_height));
        check_value("o_rom_mode", 32'd0, 32'(o_rom_mode));

        // daisy order puts the I/O block first
        run_req(OP_CONFIGURE, IO_BASE, 3'd1, 16'h0);
        run_req(OP_CONFIGURE, RAM_BASE, 3'd1, 16'h0);
        for (int k = 0; k < NUM_RAND; k++) begin
            saved_cnt[k] = 3'($urandom_range(1, 4));
            saved_addr[k] = RAM_BASE + 20'($urandom_range(0, RAM_WIN - 4));
            run_req(OP_WRITE, saved_addr[k], saved_cnt[k], 16'($urandom));
            run_req(OP_READ, saved_addr[k], saved_cnt[k], 16'h0);
        end

        // menu height and ROM mode through offsets 0x28 and 0x29
        nib_lo = 4'($urandom);
        nib_hi = {1'b1, 3'($urandom)};
        run_req(OP_WRITE, IO_BASE + 20'h28, 3'd2, {8'h0, nib_hi, nib_lo});
        run_req(OP_READ, IO_BASE + 20'h28, 3'd2, 16'h0);

        // outside both windows while the low offset bits land on written nibbles
        run_req(OP_READ, 20'h50028, 3'd2, 16'h0);
        run_req(OP_READ, 20'h50000 + (saved_addr[0] - RAM_BASE), saved_cnt[0], 16'h0);

        run_req(OP_WRITE, IO_BASE + 20'h29, 3'd1, {12'h0, 1'b0, 3'($urandom)});

        run_req(OP_RESET, 20'h0, 3'd1, 16'h0);
        run_req(OP_READ, IO_BASE + 20'h28, 3'd2, 16'h0);
        run_req(OP_READ, saved_addr[0], saved_cnt[0], 16'h0);
        run_req(OP_WRITE, IO_BASE + 20'h28, 3'd1, {12'h0, ~exp_menu[3:0]});

        run_req(OP_CONFIGURE, IO_BASE, 3'd1, 16'h0);
        run_req(OP_CONFIGURE, RAM_BASE, 3'd1, 16'h0);
        for (int k = 0; k < NUM_RAND; k++)
            run_req(OP_READ, saved_addr[k], saved_cnt[k], 16'h0);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/saturn_bus_top.sv ====
// nibble bus subsystem top joining the master, I/O block and RAM on one daisy chain
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_top
    import saturn_bus_pkg::*;
#(
    parameter int BUS_DIV  = 4,
    parameter int IO_BITS  = 6,
    parameter int RAM_BITS = 8
) (
    input  wire            i_clk,
    input  wire            i_reset,
    input  wire            i_req_valid,
    input  wire host_req_t i_req,
    output logic           o_busy,
    output logic           o_rd_done,
    output logic [15:0]    o_rd_data,
    output logic [5:0]     o_menu_height,
    output logic           o_rom_mode
);

    bus_fwd_t   bus;
    dev_rsp_t   io_rsp;
    dev_rsp_t   ram_rsp;
    logic       io_daisy;
    logic [3:0] rsp_nibble;

    // wired-or of the answers from claiming devices
    assign rsp_nibble = (io_rsp.active ? io_rsp.nibble : 4'h0) |
                        (ram_rsp.active ? ram_rsp.nibble : 4'h0);

    saturn_bus_master #(
        .BUS_DIV(BUS_DIV)
    ) u_master (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_rsp_nibble(rsp_nibble),
        .o_bus       (bus),
        .o_busy      (o_busy),
        .o_rd_done   (o_rd_done),
        .o_rd_data   (o_rd_data)
    );

    // head of the chain configures first
    saturn_io_regs #(
        .IO_BITS(IO_BITS)
    ) u_io_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus        (bus),
        .i_daisy      (1'b1),
        .o_daisy      (io_daisy),
        .o_rsp        (io_rsp),
        .o_menu_height(o_menu_height),
        .o_rom_mode   (o_rom_mode)
    );

    // end of chain leaves its daisy output open
    saturn_nibble_ram #(
        .RAM_BITS(RAM_BITS)
    ) u_nibble_ram (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .i_bus  (bus),
        .i_daisy(io_daisy),
        .o_daisy(),
        .o_rsp  (ram_rsp)
    );

endmodule

`default_nettype wire

// ==== rtl/saturn_nibble_ram.sv ====
// daisy-chained general nibble RAM device sharing the bus protocol of the I/O block
`timescale 1ns/1ps
`default_nettype none

module saturn_nibble_ram
    import saturn_bus_pkg::*;
#(
    parameter int RAM_BITS = 8
) (
    input  wire           i_clk,
    input  wire           i_reset,
    input  wire bus_fwd_t i_bus,
    input  wire           i_daisy,
    output logic          o_daisy,
    output dev_rsp_t      o_rsp
);

    logic [3:0]          ram [2**RAM_BITS];
    bus_cmd_e            last_cmd;
    logic [2:0]          addr_pos;
    logic [ADDR_W-1:0]   local_dp;
    logic [ADDR_W-1:0]   base_addr;
    logic                configured;
    logic                dp_hit;
    logic [ADDR_W-1:0]   offset;
    logic [RAM_BITS-1:0] ram_addr;
    logic [3:0]          rsp_nibble;
    logic                active;
    logic                data_strobe;

    assign offset      = local_dp - base_addr;
    assign ram_addr    = offset[RAM_BITS-1:0];
    assign active      = dp_hit && ((last_cmd == DP_READ) || (last_cmd == DP_WRITE));
    assign data_strobe = i_bus.strobe && i_bus.is_data;
    assign o_daisy     = configured;
    assign o_rsp       = '{nibble: rsp_nibble, active: active};

    always_ff @(posedge i_clk) begin
        if (i_reset)
            dp_hit <= 1'b0;
        else
            dp_hit <= configured && (offset[ADDR_W-1:RAM_BITS] == '0);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= PC_READ;
            addr_pos   <= '0;
            local_dp   <= '0;
            base_addr  <= '0;
            configured <= 1'b0;
        end else if (i_bus.strobe && !i_bus.is_data) begin
            last_cmd <= bus_cmd_e'(i_bus.nibble);
            addr_pos <= '0;
            if (bus_cmd_e'(i_bus.nibble) == RESET) begin
                base_addr  <= '0;
                configured <= 1'b0;
            end
        end else if (data_strobe) begin
            case (last_cmd)
                DP_READ, DP_WRITE: local_dp <= local_dp + 1'b1;
                LOAD_PC: begin
                    addr_pos <= addr_pos + 3'd1;
                    if (addr_pos == 3'd4)
                        last_cmd <= PC_READ;
                end
                LOAD_DP: begin
                    local_dp[addr_pos*4 +: 4] <= i_bus.nibble;
                    addr_pos <= addr_pos + 3'd1;
                    if (addr_pos == 3'd4)
                        last_cmd <= DP_READ;
                end
                CONFIGURE: begin
                    if (i_daisy && !configured) begin
                        base_addr[addr_pos*4 +: 4] <= i_bus.nibble;
                        addr_pos <= addr_pos + 3'd1;
                        if (addr_pos == 3'd4)
                            configured <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (data_strobe && active && (last_cmd == DP_WRITE))
            ram[ram_addr] <= i_bus.nibble;
    end

    // zero unless this device answered the read
    always_ff @(posedge i_clk) begin
        if (i_reset)
            rsp_nibble <= 4'h0;
        else if (data_strobe && active && (last_cmd == DP_READ))
            rsp_nibble <= ram[ram_addr];
        else
            rsp_nibble <= 4'h0;
    end

endmodule

`default_nettype wire

// ==== rtl/saturn_io_regs.sv ====
// daisy-chained I/O device with a nibble RAM window and decoded menu-height and ROM-mode registers
`timescale 1ns/1ps
`default_nettype none

module saturn_io_regs
    import saturn_bus_pkg::*;
#(
    parameter int IO_BITS = 6
) (
    input  wire           i_clk,
    input  wire           i_reset,
    input  wire bus_fwd_t i_bus,
    input  wire           i_daisy,
    output logic          o_daisy,
    output dev_rsp_t      o_rsp,
    output logic [5:0]    o_menu_height,
    output logic          o_rom_mode
);

    localparam logic [IO_BITS-1:0] MENU_LO_OFS = IO_BITS'('h28);
    localparam logic [IO_BITS-1:0] MENU_HI_OFS = IO_BITS'('h29);

    logic [3:0]         io_ram [2**IO_BITS];
    bus_cmd_e           last_cmd;
    logic [2:0]         addr_pos;
    logic [ADDR_W-1:0]  local_dp;
    logic [ADDR_W-1:0]  base_addr;
    logic               configured;
    logic               dp_hit;
    logic [ADDR_W-1:0]  offset;
    logic [IO_BITS-1:0] ram_addr;
    logic [3:0]         rsp_nibble;
    logic               use_dp;
    logic               active;
    logic               cmd_strobe;
    logic               data_strobe;
    logic               can_read;
    logic               can_write;

    assign offset      = local_dp - base_addr;
    assign ram_addr    = offset[IO_BITS-1:0];
    assign use_dp      = (last_cmd == DP_READ) || (last_cmd == DP_WRITE);
    assign active      = dp_hit && use_dp;
    assign cmd_strobe  = i_bus.strobe && !i_bus.is_data;
    assign data_strobe = i_bus.strobe && i_bus.is_data;
    assign can_read    = data_strobe && active && (last_cmd == DP_READ);
    assign can_write   = data_strobe && active && (last_cmd == DP_WRITE);

    assign o_daisy = configured;
    assign o_rsp   = '{nibble: rsp_nibble, active: active};

    // window compare settles before the next strobe
    always_ff @(posedge i_clk) begin
        if (i_reset)
            dp_hit <= 1'b0;
        else
            dp_hit <= configured && (offset[ADDR_W-1:IO_BITS] == '0);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= PC_READ;
            addr_pos   <= '0;
            local_dp   <= '0;
            base_addr  <= '0;
            configured <= 1'b0;
        end else if (cmd_strobe) begin
            last_cmd <= bus_cmd_e'(i_bus.nibble);
            addr_pos <= '0;
            if (bus_cmd_e'(i_bus.nibble) == RESET) begin
                base_addr  <= '0;
                configured <= 1'b0;
            end
        end else if (data_strobe) begin
            case (last_cmd)
                DP_READ, DP_WRITE: local_dp <= local_dp + 1'b1;
                // PC address nibbles are only counted
                LOAD_PC: begin
                    addr_pos <= addr_pos + 3'd1;
                    if (addr_pos == 3'd4)
                        last_cmd <= PC_READ;
                end
                LOAD_DP: begin
                    local_dp[addr_pos*4 +: 4] <= i_bus.nibble;
                    addr_pos <= addr_pos + 3'd1;
                    if (addr_pos == 3'd4)
                        last_cmd <= DP_READ;
                end
                // only the first unconfigured device in the chain listens
                CONFIGURE: begin
                    if (i_daisy && !configured) begin
                        base_addr[addr_pos*4 +: 4] <= i_bus.nibble;
                        addr_pos <= addr_pos + 3'd1;
                        if (addr_pos == 3'd4)
                            configured <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (can_write)
            io_ram[ram_addr] <= i_bus.nibble;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            rsp_nibble <= 4'h0;
        else
            rsp_nibble <= can_read ? io_ram[ram_addr] : 4'h0;
    end

    // decoded registers shadow their RAM locations
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_menu_height <= '0;
            o_rom_mode    <= 1'b0;
        end else if (can_write) begin
            if (ram_addr == MENU_LO_OFS)
                o_menu_height[3:0] <= i_bus.nibble;
            if (ram_addr == MENU_HI_OFS) begin
                o_menu_height[5:4] <= i_bus.nibble[1:0];
                o_rom_mode         <= i_bus.nibble[3];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/saturn_bus_master.sv ====
// bus master that sequences one host request into strobed bus nibbles and collects read data
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_master
    import saturn_bus_pkg::*;
#(
    parameter int BUS_DIV = 4
) (
    input  wire            i_clk,
    input  wire            i_reset,
    input  wire            i_req_valid,
    input  wire host_req_t i_req,
    input  wire [3:0]      i_rsp_nibble,
    output bus_fwd_t       o_bus,
    output logic           o_busy,
    output logic           o_rd_done,
    output logic [15:0]    o_rd_data
);

    localparam int DIV_W = $clog2(BUS_DIV);

    // state names the kind of bus slot in progress
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        WCMD,
        DATA,
        DONE
    } state_e;

    state_e            state;
    host_req_t         req_q;
    logic [ADDR_W-1:0] addr_sh;
    logic [15:0]       wdata_sh;
    logic [DIV_W-1:0]  div_cnt;
    logic [2:0]        nib_cnt;
    logic [2:0]        cap_cnt;
    logic              rd_pending;
    logic              slot_end;
    logic              slot_pre_end;
    logic              last_slot;
    logic              accept;
    logic              is_read;
    bus_cmd_e          first_cmd;

    assign accept       = (state == IDLE) && i_req_valid;
    assign is_read      = (req_q.op == OP_READ);
    assign slot_end     = (div_cnt == DIV_W'(BUS_DIV - 1));
    assign slot_pre_end = (div_cnt == DIV_W'(BUS_DIV - 2));
    assign o_busy       = (state != IDLE);

    // does the current slot end the sequence
    always_comb begin
        case (state)
            CMD:     last_slot = (req_q.op == OP_RESET);
            ADDR:    last_slot = (req_q.op == OP_CONFIGURE) && (nib_cnt == 3'd4);
            DATA:    last_slot = (nib_cnt == req_q.count - 3'd1);
            default: last_slot = 1'b0;
        endcase
    end

    always_comb begin
        case (req_q.op)
            OP_CONFIGURE: first_cmd = CONFIGURE;
            OP_RESET:     first_cmd = RESET;
            default:      first_cmd = LOAD_DP;
        endcase
    end

    // strobe on the first clock of every slot
    always_comb begin
        o_bus.strobe  = (state inside {CMD, ADDR, WCMD, DATA}) && (div_cnt == '0);
        o_bus.is_data = (state == ADDR) || (state == DATA);
        case (state)
            CMD:     o_bus.nibble = first_cmd;
            ADDR:    o_bus.nibble = addr_sh[3:0];
            WCMD:    o_bus.nibble = DP_WRITE;
            DATA:    o_bus.nibble = is_read ? 4'h0 : wdata_sh[3:0];
            default: o_bus.nibble = 4'h0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= IDLE;
            div_cnt <= '0;
            nib_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= CMD;
                        div_cnt <= '0;
                        nib_cnt <= '0;
                    end
                end
                // last clock of the final slot
                DONE: state <= IDLE;
                default: begin
                    div_cnt <= slot_end ? '0 : div_cnt + 1'b1;
                    if (last_slot && slot_pre_end) begin
                        state <= DONE;
                    end else if (slot_end) begin
                        case (state)
                            CMD: state <= ADDR;
                            ADDR: begin
                                if (nib_cnt == 3'd4) begin
                                    nib_cnt <= '0;
                                    state   <= (req_q.op == OP_WRITE) ? WCMD : DATA;
                                end else begin
                                    nib_cnt <= nib_cnt + 3'd1;
                                end
                            end
                            WCMD: state <= DATA;
                            default: nib_cnt <= nib_cnt + 3'd1;
                        endcase
                    end
                end
            endcase
        end
    end

    // address and write data leave low nibble first
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q    <= i_req;
            addr_sh  <= i_req.addr;
            wdata_sh <= i_req.wdata;
        end else if (slot_end) begin
            if (state == ADDR)
                addr_sh <= addr_sh >> 4;
            if (state == DATA)
                wdata_sh <= wdata_sh >> 4;
        end
    end

    // merged device nibble is valid the clock after a read strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_pending <= 1'b0;
            cap_cnt    <= '0;
            o_rd_done  <= 1'b0;
            o_rd_data  <= '0;
        end else begin
            rd_pending <= o_bus.strobe && (state == DATA) && is_read;
            o_rd_done  <= 1'b0;
            if (accept && (i_req.op == OP_READ)) begin
                cap_cnt   <= '0;
                o_rd_data <= '0;
            end else if (rd_pending) begin
                o_rd_data[cap_cnt*4 +: 4] <= i_rsp_nibble;
                cap_cnt   <= cap_cnt + 3'd1;
                o_rd_done <= (cap_cnt == req_q.count - 3'd1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/saturn_bus_pkg.sv ====
// shared nibble bus types and constants imported by the bus master, both devices and the top
`default_nettype none

package saturn_bus_pkg;

    // bus address width set by the five-nibble address format
    localparam int ADDR_W = 20;

    // command nibbles as they travel on the bus
    typedef enum logic [3:0] {
        PC_READ   = 4'h0,
        DP_READ   = 4'h1,
        PC_WRITE  = 4'h2,
        DP_WRITE  = 4'h3,
        LOAD_PC   = 4'h4,
        LOAD_DP   = 4'h5,
        CONFIGURE = 4'h6,
        RESET     = 4'h8
    } bus_cmd_e;

    typedef enum logic [1:0] {
        OP_CONFIGURE,
        OP_READ,
        OP_WRITE,
        OP_RESET
    } host_op_e;

    // one host request of 1 to 4 nibbles
    typedef struct packed {
        host_op_e          op;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        count;
        logic [15:0]       wdata;
    } host_req_t;

    // master to devices with one strobe per bus cycle
    typedef struct packed {
        logic       strobe;
        logic       is_data;
        logic [3:0] nibble;
    } bus_fwd_t;

    // device answer with a zero nibble unless the device answered
    typedef struct packed {
        logic [3:0] nibble;
        logic       active;
    } dev_rsp_t;

endpackage

`default_nettype wire
